/* sim.f */
+incdir+logic
logic/leaf_pkg.sv
logic/packet_unpack.sv
logic/port_fifo.sv
logic/add_kernel.sv
logic/packet_pack.sv
logic/leaf_top.sv
testbench/leaf_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the leaf testbench with Verilator and runs it.
set -u
cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing --assert -j 0 --top-module leaf_tb \
    -f sim.f -o leaf_tb_sim > "$BUILD_LOG" 2>&1
if [ $? -ne 0 ]; then
    cat "$BUILD_LOG"
    echo "build failed"
    exit 1
fi

./obj_dir/leaf_tb_sim > "$SIM_LOG" 2>&1
status=$?
cat "$SIM_LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "All checks passed" "$SIM_LOG"; then
    exit 0
fi
exit 1

/* testbench/leaf_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module leaf_tb;

    localparam int NUM_OPS     = 600;
    localparam int NUM_PRE     = 12;
    localparam int CFG_EVERY   = 150;
    localparam int MAX_PENDING = 6;
    localparam int TIMEOUT     = (NUM_OPS + NUM_PRE) * 20 + 2000;

    logic              clk;
    logic              arst_n;
    leaf_pkg::packet_t din_leaf_bft2interface;
    leaf_pkg::packet_t dout_leaf_interface2bft;
    logic              resend;
    logic              ap_start;
    logic              overflow;

    integer seed;
    int     errors;
    int     checked;
    int     resend_left;
    bit     running;
    bit     started;

    // words injected per data port whose sum has not come out yet.
    logic [31:0] q1[$];
    logic [31:0] q2[$];
    logic [4:0]  cur_leaf;
    logic [3:0]  cur_port;
    logic [6:0]  exp_tag;

    leaf_top leaf_top_i (
        .clk                     (clk),
        .arst_n                  (arst_n),
        .din_leaf_bft2interface  (din_leaf_bft2interface),
        .dout_leaf_interface2bft (dout_leaf_interface2bft),
        .resend                  (resend),
        .ap_start                (ap_start),
        .overflow                (overflow)
    );

    always #20 clk = ~clk;

    function automatic leaf_pkg::packet_t make_packet(input logic valid, input logic [3:0] port,
                                                      input logic [31:0] payload);
        logic [4:0] leaf;
        logic [6:0] tag;
        leaf = 5'($random(seed)); // the incoming leaf and tag fields mean nothing here.
        tag  = 7'($random(seed));
        return {valid, leaf, port, tag, payload};
    endfunction

    task automatic next_cycle;
        @(posedge clk);
        #2;
    endtask

    task automatic inject_word(input int port);
        logic [31:0] word;
        word = $random(seed);
        din_leaf_bft2interface = make_packet(1'b1, 4'(port), word);
        if (port == 1) begin
            q1.push_back(word);
        end else begin
            q2.push_back(word);
        end
    endtask

    task automatic random_op;
        int unsigned r;
        r = $unsigned($random(seed)) % 100;
        if (r < 40 && q1.size() <= MAX_PENDING) begin
            inject_word(1);
        end else if (r >= 40 && r < 80 && q2.size() <= MAX_PENDING) begin
            inject_word(2);
        end else if (r >= 80 && r < 86) begin
            din_leaf_bft2interface = make_packet(1'b1, 4'(3 + $unsigned($random(seed)) % 13),
                                                 $random(seed));
        end else if (r >= 86 && r < 92) begin
            // a cleared valid bit on a live port, configuration included.
            din_leaf_bft2interface = make_packet(1'b0, 4'($unsigned($random(seed)) % 3),
                                                 $random(seed));
        end else begin
            din_leaf_bft2interface = '0;
        end
    endtask

    task automatic update_resend;
        if (resend_left > 0) begin
            resend_left = resend_left - 1;
            resend = 1'b1;
        end else if ($unsigned($random(seed)) % 40 == 0) begin
            resend = 1'b1;
            resend_left = int'($unsigned($random(seed)) % 20);
        end else begin
            resend = 1'b0;
        end
    endtask

    // evens out the two queues and waits until every sum has come out.
    task automatic drain;
        while (q1.size() != 0 || q2.size() != 0) begin
            next_cycle;
            resend = 1'b0;
            if (q1.size() < q2.size()) begin
                inject_word(1);
            end else if (q2.size() < q1.size()) begin
                inject_word(2);
            end else begin
                din_leaf_bft2interface = '0;
            end
        end
        next_cycle;
        din_leaf_bft2interface = '0;
    endtask

    task automatic configure;
        logic [31:0] word;
        word = $random(seed);
        next_cycle;
        din_leaf_bft2interface = make_packet(1'b1, 4'd0, word);
        cur_leaf = word[8:4];
        cur_port = word[3:0];
        next_cycle;
        din_leaf_bft2interface = '0;
        repeat (2) next_cycle;
    endtask

    task automatic check_outputs;
        leaf_pkg::packet_t expected;
        logic [31:0]       sum;
        if (overflow !== 1'b0) begin
            errors++;
            $display("error overflow got %h expected 0", overflow);
        end
        if (resend && dout_leaf_interface2bft !== '0) begin
            errors++;
            $display("error dout_leaf_interface2bft got %h expected 0 during resend",
                     dout_leaf_interface2bft);
        end else if (!started && dout_leaf_interface2bft !== '0) begin
            errors++;
            $display("error dout_leaf_interface2bft got %h expected 0 before start",
                     dout_leaf_interface2bft);
        end else if (dout_leaf_interface2bft[48] !== 1'b1) begin
            if (dout_leaf_interface2bft !== '0) begin
                errors++;
                $display("error dout_leaf_interface2bft got %h expected 0",
                         dout_leaf_interface2bft);
            end
        end else if (q1.size() == 0 || q2.size() == 0) begin
            errors++;
            $display("an outgoing packet came out with no pair of words left to match it");
        end else begin
            sum = q1.pop_front() + q2.pop_front(); // the carry out of bit 31 is dropped.
            expected = {1'b1, cur_leaf, cur_port, exp_tag, sum};
            if (dout_leaf_interface2bft !== expected) begin
                errors++;
                $display("error dout_leaf_interface2bft got %h expected %h",
                         dout_leaf_interface2bft, expected);
            end
            exp_tag = exp_tag + 7'd1;
            checked++;
        end
    endtask

    always @(negedge clk) begin
        if (running) begin
            check_outputs;
        end
    end

    initial begin
        clk = 1'b0;
        arst_n = 1'b0;
        din_leaf_bft2interface = '0;
        resend = 1'b0;
        ap_start = 1'b0;
        seed = 32'h317a_6c4a;
        errors = 0;
        checked = 0;
        resend_left = 0;
        running = 1'b0;
        started = 1'b0;
        cur_leaf = '0;
        cur_port = '0;
        exp_tag = '0;
        repeat (16) @(posedge clk);
        #2;
        arst_n = 1'b1;
        running = 1'b1;

        // words sit in the FIFOs while the kernel is still idle.
        for (int i = 0; i < NUM_PRE; i++) begin
            next_cycle;
            inject_word(1 + i % 2);
        end
        next_cycle;
        din_leaf_bft2interface = '0;
        repeat (20) next_cycle;
        ap_start = 1'b1;
        started = 1'b1;
        next_cycle;
        ap_start = 1'b0;
        drain;
        configure;

        for (int i = 0; i < NUM_OPS; i++) begin
            if (i % CFG_EVERY == CFG_EVERY / 2) begin
                drain;
                configure;
            end
            next_cycle;
            update_resend;
            random_op;
        end
        drain;
        repeat (10) next_cycle;

        if (checked < 130) begin
            errors++;
            $display("only %0d packets came out, too few for the tag to wrap", checked);
        end
        $display("errors %0d, packets checked %0d", errors, checked);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

    initial begin
        repeat (TIMEOUT) @(posedge clk);
        $display("the run timed out after %0d cycles", TIMEOUT);
        $display("errors %0d, packets checked %0d", errors, checked);
        $display("Checks failed");
        $finish;
    end

endmodule

`default_nettype wire

/* logic/leaf_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "leaf_defs.svh"

module leaf_top (
    input  wire                     clk,
    input  wire                     arst_n,
    input  wire leaf_pkg::packet_t  din_leaf_bft2interface,
    output leaf_pkg::packet_t       dout_leaf_interface2bft,
    input  wire                     resend,
    input  wire                     ap_start,
    output logic                    overflow
);

    logic                        cfg_wr;
    leaf_pkg::leaf_t             cfg_leaf;
    leaf_pkg::port_t             cfg_port;
    logic [`NUM_DATA_PORTS-1:0]  push;
    logic [`NUM_DATA_PORTS-1:0]  full;
    leaf_pkg::payload_t          push_data;  // shared by both FIFOs, push selects the one.

    logic [`NUM_DATA_PORTS-1:0]  vld_interface2user;
    logic [`NUM_DATA_PORTS-1:0]  ack_user2interface;
    leaf_pkg::payload_t          dout_leaf_interface2user_1;
    leaf_pkg::payload_t          dout_leaf_interface2user_2;

    logic                        vld_user2interface;
    logic                        ack_interface2user;
    leaf_pkg::payload_t          din_leaf_user2interface;

    packet_unpack packet_unpack_i (
        .clk                    (clk),
        .arst_n                 (arst_n),
        .din_leaf_bft2interface (din_leaf_bft2interface),
        .full                   (full),
        .push                   (push),
        .push_data              (push_data),
        .cfg_wr                 (cfg_wr),
        .cfg_leaf               (cfg_leaf),
        .cfg_port               (cfg_port),
        .overflow               (overflow)
    );

    port_fifo port_fifo_1_i (
        .clk                      (clk),
        .arst_n                   (arst_n),
        .push                     (push[0]),
        .push_data                (push_data),
        .full                     (full[0]),
        .vld_interface2user       (vld_interface2user[0]),
        .dout_leaf_interface2user (dout_leaf_interface2user_1),
        .ack_user2interface       (ack_user2interface[0])
    );

    port_fifo port_fifo_2_i (
        .clk                      (clk),
        .arst_n                   (arst_n),
        .push                     (push[1]),
        .push_data                (push_data),
        .full                     (full[1]),
        .vld_interface2user       (vld_interface2user[1]),
        .dout_leaf_interface2user (dout_leaf_interface2user_2),
        .ack_user2interface       (ack_user2interface[1])
    );

    add_kernel add_kernel_i (
        .clk                        (clk),
        .arst_n                     (arst_n),
        .ap_start                   (ap_start),
        .vld_interface2user         (vld_interface2user),
        .dout_leaf_interface2user_1 (dout_leaf_interface2user_1),
        .dout_leaf_interface2user_2 (dout_leaf_interface2user_2),
        .ack_user2interface         (ack_user2interface),
        .vld_user2interface         (vld_user2interface),
        .din_leaf_user2interface    (din_leaf_user2interface),
        .ack_interface2user         (ack_interface2user)
    );

    packet_pack packet_pack_i (
        .clk                     (clk),
        .arst_n                  (arst_n),
        .resend                  (resend),
        .cfg_wr                  (cfg_wr),
        .cfg_leaf                (cfg_leaf),
        .cfg_port                (cfg_port),
        .vld_user2interface      (vld_user2interface),
        .din_leaf_user2interface (din_leaf_user2interface),
        .ack_interface2user      (ack_interface2user),
        .dout_leaf_interface2bft (dout_leaf_interface2bft)
    );

endmodule

`default_nettype wire

/* logic/packet_pack.sv */
`timescale 1ns/1ps
`default_nettype none

`include "leaf_defs.svh"

module packet_pack (
    input  wire                     clk,
    input  wire                     arst_n,
    input  wire                     resend,
    input  wire                     cfg_wr,
    input  wire leaf_pkg::leaf_t    cfg_leaf,
    input  wire leaf_pkg::port_t    cfg_port,
    input  wire                     vld_user2interface,
    input  wire leaf_pkg::payload_t din_leaf_user2interface,
    output logic                    ack_interface2user,
    output leaf_pkg::packet_t       dout_leaf_interface2bft
);

    leaf_pkg::leaf_t   dest_leaf;
    leaf_pkg::port_t   dest_port;
    leaf_pkg::tag_t    tag;
    leaf_pkg::packet_t pkt_next;
    leaf_pkg::packet_t pkt_q;

    assign ack_interface2user = vld_user2interface && !resend;

    always_comb begin
        pkt_next                            = '0;
        pkt_next[`VALID_BIT]                = 1'b1;
        pkt_next[`LEAF_MSB:`LEAF_LSB]       = dest_leaf;
        pkt_next[`PORT_MSB:`PORT_LSB]       = dest_port;
        pkt_next[`TAG_MSB:`TAG_LSB]         = tag;
        pkt_next[`PAYLOAD_MSB:`PAYLOAD_LSB] = din_leaf_user2interface;
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            dest_leaf <= '0;
            dest_port <= '0;
            tag       <= '0;
            pkt_q     <= '0;
        end else begin
            if (cfg_wr) begin
                dest_leaf <= cfg_leaf;
                dest_port <= cfg_port;
            end
            if (ack_interface2user) begin
                pkt_q <= pkt_next;
                tag   <= tag + 1'b1; // wraps from 127 to 0.
            end else if (!resend) begin
                pkt_q <= '0;
            end
            // A packet built just before resend rises is held and goes out once it falls.
        end
    end

    assign dout_leaf_interface2bft = resend ? '0 : pkt_q;

    a_resend_zero: assert property (@(posedge clk) disable iff (!arst_n)
        resend |-> (dout_leaf_interface2bft == '0))
        else $error("packet_pack: bus not zero during resend");

endmodule

`default_nettype wire

/* logic/add_kernel.sv */
`timescale 1ns/1ps
`default_nettype none

`include "leaf_defs.svh"

module add_kernel (
    input  wire                          clk,
    input  wire                          arst_n,
    input  wire                          ap_start,
    input  wire [`NUM_DATA_PORTS-1:0]    vld_interface2user,
    input  wire leaf_pkg::payload_t      dout_leaf_interface2user_1,
    input  wire leaf_pkg::payload_t      dout_leaf_interface2user_2,
    output logic [`NUM_DATA_PORTS-1:0]   ack_user2interface,
    output logic                         vld_user2interface,
    output leaf_pkg::payload_t           din_leaf_user2interface,
    input  wire                          ack_interface2user
);

    leaf_pkg::kernel_state_t state;
    logic                    take;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= leaf_pkg::ks_idle;
        end else if ((state == leaf_pkg::ks_idle) && ap_start) begin
            state <= leaf_pkg::ks_run; // no way back to idle short of reset.
        end
    end

    // both words are taken together, and only if the result slot frees up this cycle.
    assign take = (state == leaf_pkg::ks_run) && (&vld_interface2user) &&
                  (!vld_user2interface || ack_interface2user);

    assign ack_user2interface = {`NUM_DATA_PORTS{take}};

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            vld_user2interface <= 1'b0;
        end else if (take) begin
            vld_user2interface <= 1'b1;
        end else if (ack_interface2user) begin
            vld_user2interface <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            // carry out of bit 31 is lost on purpose.
            din_leaf_user2interface <= dout_leaf_interface2user_1 + dout_leaf_interface2user_2;
        end
    end

endmodule

`default_nettype wire

/* logic/port_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

`include "leaf_defs.svh"

module port_fifo (
    input  wire                     clk,
    input  wire                     arst_n,
    input  wire                     push,
    input  wire leaf_pkg::payload_t push_data,
    output logic                    full,
    output logic                    vld_interface2user,
    output leaf_pkg::payload_t      dout_leaf_interface2user,
    input  wire                     ack_user2interface
);

    leaf_pkg::payload_t          mem [`FIFO_DEPTH];
    logic [`FIFO_ADDR_BITS-1:0]  wr_ptr;
    logic [`FIFO_ADDR_BITS-1:0]  rd_ptr;
    logic [`FIFO_ADDR_BITS:0]    count; // one bit wider than the pointers to tell full from empty.

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (ack_user2interface) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, ack_user2interface})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count; // both or neither leave the fill level alone.
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    assign full                     = (count == (`FIFO_ADDR_BITS+1)'(`FIFO_DEPTH));
    assign vld_interface2user       = (count != '0);
    assign dout_leaf_interface2user = mem[rd_ptr]; // head word, valid while vld is high.

    a_no_push_full: assert property (@(posedge clk) disable iff (!arst_n)
        push |-> !full)
        else $error("port_fifo: push while full");

    a_ack_vld: assert property (@(posedge clk) disable iff (!arst_n)
        ack_user2interface |-> vld_interface2user)
        else $error("port_fifo: ack without a word offered");

endmodule

`default_nettype wire

/* logic/packet_unpack.sv */
`timescale 1ns/1ps
`default_nettype none

`include "leaf_defs.svh"

module packet_unpack (
    input  wire                          clk,
    input  wire                          arst_n,
    input  wire leaf_pkg::packet_t       din_leaf_bft2interface,
    input  wire [`NUM_DATA_PORTS-1:0]    full,
    output logic [`NUM_DATA_PORTS-1:0]   push,
    output leaf_pkg::payload_t           push_data,
    output logic                         cfg_wr,
    output leaf_pkg::leaf_t              cfg_leaf,
    output leaf_pkg::port_t              cfg_port,
    output logic                         overflow
);

    logic                        pkt_valid;
    leaf_pkg::port_t             pkt_port;
    logic                        cfg_d;
    logic [`NUM_DATA_PORTS-1:0]  req_d;
    logic [`NUM_DATA_PORTS-1:0]  req_q;
    leaf_pkg::payload_t          data_q;

    assign pkt_valid = din_leaf_bft2interface[`VALID_BIT];
    assign pkt_port  = din_leaf_bft2interface[`PORT_MSB:`PORT_LSB];

    // port 0 is configuration, data port i is reached through packet port i+1.
    always_comb begin
        cfg_d = pkt_valid && (pkt_port == leaf_pkg::port_t'(`CFG_PORT));
        for (int i = 0; i < `NUM_DATA_PORTS; i++) begin
            req_d[i] = pkt_valid && (pkt_port == leaf_pkg::port_t'(i + 1));
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            req_q    <= '0;
            cfg_wr   <= 1'b0;
            overflow <= 1'b0;
        end else begin
            req_q  <= req_d;
            cfg_wr <= cfg_d;
            if (|(req_q & full)) begin
                overflow <= 1'b1; // sticky, only reset clears it.
            end
        end
    end

    // one payload register serves both the FIFO data and the configuration fields.
    always_ff @(posedge clk) begin
        if (pkt_valid) begin
            data_q <= din_leaf_bft2interface[`PAYLOAD_MSB:`PAYLOAD_LSB];
        end
    end

    // A word headed for a full FIFO is dropped here.
    assign push      = req_q & ~full;
    assign push_data = data_q;
    assign cfg_leaf  = data_q[`CFG_LEAF_MSB:`CFG_LEAF_LSB];
    assign cfg_port  = data_q[`CFG_PORT_MSB:`CFG_PORT_LSB];

    a_push_onehot: assert property (@(posedge clk) disable iff (!arst_n)
        $onehot0(push))
        else $error("packet_unpack: more than one FIFO pushed in one cycle");

endmodule

`default_nettype wire

/* logic/leaf_pkg.sv */
`default_nettype none

`include "leaf_defs.svh"

package leaf_pkg;

    typedef logic [`PACKET_BITS-1:0] packet_t; // one packet as seen on the network bus.

    typedef logic [`PAYLOAD_BITS-1:0] payload_t;

    typedef logic [`LEAF_BITS-1:0] leaf_t;

    typedef logic [`PORT_BITS-1:0] port_t;

    // sequence number of an outgoing packet, wraps at 128.
    typedef logic [`TAG_BITS-1:0] tag_t;

    // the kernel sits idle until the host starts it and then runs until reset.
    typedef enum logic {
        ks_idle,
        ks_run
    } kernel_state_t;

endpackage

`default_nettype wire

/* logic/leaf_defs.svh */
`ifndef LEAF_DEFS_SVH
`define LEAF_DEFS_SVH

// widths of one network packet and its fields.
`define PACKET_BITS 49
`define PAYLOAD_BITS 32
`define LEAF_BITS 5
`define PORT_BITS 4
`define TAG_BITS 7

// field positions inside a packet, valid bit on top.
`define VALID_BIT 48
`define LEAF_MSB 47
`define LEAF_LSB 43
`define PORT_MSB 42
`define PORT_LSB 39
`define TAG_MSB 38
`define TAG_LSB 32
`define PAYLOAD_MSB 31
`define PAYLOAD_LSB 0

// a configuration packet carries the new destination in its payload.
`define CFG_PORT 0
`define CFG_LEAF_MSB 8
`define CFG_LEAF_LSB 4
`define CFG_PORT_MSB 3
`define CFG_PORT_LSB 0

`define NUM_DATA_PORTS 2

// words per port FIFO, kept a power of two so the pointers wrap by themselves.
`define FIFO_DEPTH 8
`define FIFO_ADDR_BITS 3

`endif
